// File: l2_mem_defines.svh
// ------------------------------------------------
// geometry of the L2 memory read path
// L2_WB_DEPTH must be a power of two
// ------------------------------------------------
`ifndef L2_MEM_DEFINES_SVH
`define L2_MEM_DEFINES_SVH

// log2 of 32-bit words per line
`define L2_OFFSET_WIDTH 2
`define L2_LINE_WORDS   4
`define L2_LINE_BITS    128

// byte address width on the memory side
`define L2_ADDR_BITS    32

// evicted lines waiting for write-back
`define L2_WB_DEPTH     4

`endif

// File: l2_mem_pkg.sv
// ------------------------------------------------
// shared line, request and buffer entry types
// line address drops the byte and word offset bits
// ------------------------------------------------
`default_nettype none

`include "l2_mem_defines.svh"

package l2_mem_pkg;

    localparam int LINE_ADDR_BITS = `L2_ADDR_BITS - `L2_OFFSET_WIDTH - 2;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // word 0 sits in the low bits
    typedef logic [`L2_LINE_WORDS-1:0][31:0] l2_line_t;

    typedef struct packed {
        line_addr_t line_addr;
        logic       dma;
        logic [2:0] size;       // axi size code, dma only
    } rd_req_t;

    typedef struct packed {
        line_addr_t line_addr;
        l2_line_t   line;
    } wb_entry_t;

    typedef struct packed {
        logic [`L2_ADDR_BITS-1:0] addr;
        logic [7:0]               len;
        logic [2:0]               size;
    } ar_req_t;

endpackage

`default_nettype wire

// File: write_buffer.sv
// ------------------------------------------------
// push must stay low while full is high
// ------------------------------------------------
`default_nettype none

`include "l2_mem_defines.svh"

module write_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   push,
    input  l2_mem_pkg::wb_entry_t  push_entry,
    output logic                   full,
    input  l2_mem_pkg::line_addr_t query_addr,
    output logic                   query_hit,
    output l2_mem_pkg::l2_line_t   query_line,
    output logic                   drain_valid,
    output l2_mem_pkg::wb_entry_t  drain_entry,
    input  logic                   drain_done
);
    import l2_mem_pkg::*;

    localparam int DEPTH   = `L2_WB_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    wb_entry_t            entries [DEPTH];
    logic [DEPTH-1:0]     vld;
    logic [PTR_BITS-1:0]  head;
    logic [PTR_BITS-1:0]  tail;
    logic [DEPTH-1:0]     push_match;
    logic [DEPTH-1:0]     query_match;
    logic [PTR_BITS-1:0]  push_idx;
    logic                 push_hit;
    logic                 drain_fire;

    assign drain_valid = vld[head];
    assign drain_entry = entries[head];
    assign full        = &vld;
    assign drain_fire  = drain_done && vld[head];

    // one comparator per entry for each port
    always_comb begin
        push_match  = '0;
        query_match = '0;
        push_idx    = '0;
        query_line  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            push_match[i]  = vld[i] && (entries[i].line_addr == push_entry.line_addr);
            query_match[i] = vld[i] && (entries[i].line_addr == query_addr);
        end
        // head leaving this cycle cannot take the rewrite
        if (drain_fire) begin
            push_match[head] = 1'b0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (push_match[i]) begin
                push_idx = PTR_BITS'(i);
            end
            if (query_match[i]) begin
                query_line = entries[i].line;
            end
        end
    end

    assign push_hit  = |push_match;
    assign query_hit = |query_match;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld  <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (drain_fire) begin
                vld[head] <= 1'b0;
                head      <= head + 1'b1;
            end
            if (push && !push_hit) begin
                vld[tail] <= 1'b1;
                tail      <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            if (push_hit) begin
                entries[push_idx] <= push_entry;
            end else begin
                entries[tail] <= push_entry;
            end
        end
    end

endmodule

`default_nettype wire

// File: read_arbiter.sv
// ------------------------------------------------
// one read in flight; dma reads never use the buffer
// ------------------------------------------------
`default_nettype none

`include "l2_mem_defines.svh"

module read_arbiter (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req,
    input  l2_mem_pkg::rd_req_t    req_info,
    output logic                   addr_ok,
    output logic                   data_ok,
    output l2_mem_pkg::l2_line_t   line_out,
    input  logic                   rdy,
    output l2_mem_pkg::line_addr_t query_addr,
    input  logic                   query_hit,
    input  l2_mem_pkg::l2_line_t   query_line,
    output logic                   fetch_req,
    output l2_mem_pkg::ar_req_t    fetch_ar,
    input  logic                   fetch_addr_ok,
    input  logic                   line_ok,
    input  l2_mem_pkg::l2_line_t   fetch_line,
    output logic                   line_rdy
);
    import l2_mem_pkg::*;

    localparam int BYTE_OFS = `L2_OFFSET_WIDTH + 2;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUF_ACCEPT,
        ST_BUF_RETURN,
        ST_FETCH_ADDR,
        ST_FETCH_RETURN
    } state_t;

    state_t   state;
    state_t   state_nxt;
    l2_line_t hit_line;
    logic     take_hit;

    assign query_addr = req_info.line_addr;
    assign take_hit   = req && !req_info.dma && query_hit;

    // line reads burst the whole line, dma reads one beat
    assign fetch_ar.addr = {req_info.line_addr, {BYTE_OFS{1'b0}}};
    assign fetch_ar.len  = req_info.dma ? 8'd0 : 8'(`L2_LINE_WORDS - 1);
    assign fetch_ar.size = req_info.dma ? req_info.size : 3'd2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (take_hit) begin
                    state_nxt = ST_BUF_ACCEPT;
                end else if (req) begin
                    state_nxt = ST_FETCH_ADDR;
                end
            end
            ST_BUF_ACCEPT: state_nxt = ST_BUF_RETURN;
            ST_BUF_RETURN: begin
                if (rdy) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_FETCH_ADDR: begin
                if (fetch_addr_ok) begin
                    state_nxt = ST_FETCH_RETURN;
                end
            end
            ST_FETCH_RETURN: begin
                if (line_ok && rdy) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // hit data frozen here, later pushes or drains do not touch it
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && take_hit) begin
            hit_line <= query_line;
        end
    end

    always_comb begin
        addr_ok   = 1'b0;
        data_ok   = 1'b0;
        line_out  = '0;
        fetch_req = 1'b0;
        line_rdy  = 1'b0;
        case (state)
            ST_BUF_ACCEPT: addr_ok = 1'b1;
            ST_BUF_RETURN: begin
                data_ok  = 1'b1;
                line_out = hit_line;
            end
            ST_FETCH_ADDR: begin
                fetch_req = 1'b1;
                addr_ok   = fetch_addr_ok;
            end
            ST_FETCH_RETURN: begin
                data_ok  = line_ok;
                line_out = fetch_line;
                line_rdy = rdy;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: return_buffer.sv
// ------------------------------------------------
// bursts longer than one line wrap into word 0
// ------------------------------------------------
`default_nettype none

`include "l2_mem_defines.svh"

module return_buffer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 fetch_req,
    input  l2_mem_pkg::ar_req_t  fetch_ar,
    output logic                 fetch_addr_ok,
    output logic                 line_ok,
    output l2_mem_pkg::l2_line_t fetch_line,
    input  logic                 line_rdy,
    output logic                 ar_valid,
    output l2_mem_pkg::ar_req_t  ar,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  logic [31:0]          r_data,
    input  logic                 r_last,
    output logic                 r_ready
);
    import l2_mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_COLLECT,
        ST_HOLD
    } state_t;

    state_t                      state;
    ar_req_t                     ar_q;
    l2_line_t                    line_q;
    logic [`L2_OFFSET_WIDTH-1:0] beat_cnt;
    logic                        ar_fire;
    logic                        r_fire;

    assign ar_valid      = (state == ST_ADDR);
    assign r_ready       = (state == ST_COLLECT);
    assign line_ok       = (state == ST_HOLD);
    assign ar            = ar_q;
    assign fetch_line    = line_q;
    assign ar_fire       = ar_valid && ar_ready;
    assign r_fire        = r_valid && r_ready;
    assign fetch_addr_ok = ar_fire;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fetch_req) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (ar_fire) begin
                        state    <= ST_COLLECT;
                        beat_cnt <= '0;
                    end
                end
                ST_COLLECT: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_last) begin
                            state <= ST_HOLD;
                        end
                    end
                end
                ST_HOLD: begin
                    if (line_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // unused words of a single-beat read stay zero
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && fetch_req) begin
            ar_q <= fetch_ar;
        end
        if (ar_fire) begin
            line_q <= '0;
        end else if (r_fire) begin
            line_q[beat_cnt] <= r_data;
        end
    end

endmodule

`default_nettype wire

// File: l2_mem_read_path.sv
// ------------------------------------------------
// write channel and drain target live outside
// ------------------------------------------------
`default_nettype none

module l2_mem_read_path (
    input  logic                  clk,
    input  logic                  rstn,
    // cache read port
    input  logic                  req,
    input  l2_mem_pkg::rd_req_t   req_info,
    output logic                  addr_ok,
    output logic                  data_ok,
    output l2_mem_pkg::l2_line_t  line_out,
    input  logic                  rdy,
    // evicted lines
    input  logic                  push,
    input  l2_mem_pkg::wb_entry_t push_entry,
    output logic                  full,
    output logic                  drain_valid,
    output l2_mem_pkg::wb_entry_t drain_entry,
    input  logic                  drain_done,
    // memory read port
    output logic                  ar_valid,
    output l2_mem_pkg::ar_req_t   ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  logic [31:0]           r_data,
    input  logic                  r_last,
    output logic                  r_ready
);
    import l2_mem_pkg::*;

    line_addr_t query_addr;
    logic       query_hit;
    l2_line_t   query_line;
    logic       fetch_req;
    ar_req_t    fetch_ar;
    logic       fetch_addr_ok;
    logic       line_ok;
    l2_line_t   fetch_line;
    logic       line_rdy;

    write_buffer wb_i (
        .clk         (clk),
        .rstn        (rstn),
        .push        (push),
        .push_entry  (push_entry),
        .full        (full),
        .query_addr  (query_addr),
        .query_hit   (query_hit),
        .query_line  (query_line),
        .drain_valid (drain_valid),
        .drain_entry (drain_entry),
        .drain_done  (drain_done)
    );

    read_arbiter arb_i (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req),
        .req_info      (req_info),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .line_out      (line_out),
        .rdy           (rdy),
        .query_addr    (query_addr),
        .query_hit     (query_hit),
        .query_line    (query_line),
        .fetch_req     (fetch_req),
        .fetch_ar      (fetch_ar),
        .fetch_addr_ok (fetch_addr_ok),
        .line_ok       (line_ok),
        .fetch_line    (fetch_line),
        .line_rdy      (line_rdy)
    );

    return_buffer rb_i (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_req     (fetch_req),
        .fetch_ar      (fetch_ar),
        .fetch_addr_ok (fetch_addr_ok),
        .line_ok       (line_ok),
        .fetch_line    (fetch_line),
        .line_rdy      (line_rdy),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .r_last        (r_last),
        .r_ready       (r_ready)
    );

endmodule

`default_nettype wire

// File: l2_mem_read_path_asserts.sv
// ------------------------------------------------
// bound into l2_mem_read_path, port handshakes only
// ------------------------------------------------
`default_nettype none

module l2_mem_read_path_asserts (
    input logic                 clk,
    input logic                 rstn,
    input logic                 req,
    input logic                 addr_ok,
    input logic                 data_ok,
    input l2_mem_pkg::l2_line_t line_out,
    input logic                 rdy,
    input logic                 push,
    input logic                 full,
    input logic                 ar_valid,
    input l2_mem_pkg::ar_req_t  ar,
    input logic                 ar_ready
);
    int fail_count = 0;

    no_push_when_full: assert property (@(posedge clk) disable iff (!rstn)
        !(push && full))
    else begin
        fail_count++;
        $error("push while the write buffer is full");
    end

    // address beat held while stalled
    ar_stable: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
        fail_count++;
        $error("ar changed or dropped before ar_ready");
    end

    line_stable: assert property (@(posedge clk) disable iff (!rstn)
        data_ok && !rdy |=> data_ok && $stable(line_out))
    else begin
        fail_count++;
        $error("data_ok or line_out changed before rdy");
    end

    addr_ok_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        addr_ok |-> req)
    else begin
        fail_count++;
        $error("addr_ok without a pending req");
    end

endmodule

bind l2_mem_read_path l2_mem_read_path_asserts asserts_i (.*);

`default_nettype wire

// File: l2_mem_read_path_tb.sv
// ------------------------------------------------
// patterns file is read from the working directory
// rows run strictly in order, one read in flight
// ------------------------------------------------
`default_nettype none

`include "l2_mem_defines.svh"

module l2_mem_read_path_tb;
    import l2_mem_pkg::*;

    localparam int MAX_ROWS = 64;
    localparam int ROW_BITS = 304;

    logic        clk;
    logic        rstn;
    logic        req;
    rd_req_t     req_info;
    logic        addr_ok;
    logic        data_ok;
    l2_line_t    line_out;
    logic        rdy;
    logic        push;
    wb_entry_t   push_entry;
    logic        full;
    logic        drain_valid;
    wb_entry_t   drain_entry;
    logic        drain_done;
    logic        ar_valid;
    ar_req_t     ar;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic        r_last;
    logic        r_ready;

    logic [ROW_BITS-1:0] rows [MAX_ROWS];
    int          n_rows;
    int          cycles = 0;
    int          limit = 0;
    integer      seed = 32'ha6acb61c;
    logic [31:0] rnd;
    // memory responder state
    int          ar_count;
    ar_req_t     ar_seen;
    int          beats_left;
    logic [31:0] beat_addr;

    l2_mem_read_path dut_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // one draw per cycle, shared by rdy and the responder
    always @(posedge clk) begin
        rnd <= $random(seed);
    end

    always @(posedge clk) begin
        if (rstn) begin
            cycles <= cycles + 1;
        end
        if (limit > 0 && cycles > limit) begin
            fail_run($sformatf("timeout, no progress after %0d cycles", cycles));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_line(input string name, input l2_line_t got, input l2_line_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_entry(input string name, input wb_entry_t got, input wb_entry_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_ar(input string name, input ar_req_t got, input ar_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    // beat k of a burst at address a carries a + 4k
    initial begin
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_data     = '0;
        r_last     = 1'b0;
        ar_count   = 0;
        ar_seen    = '0;
        beats_left = 0;
        beat_addr  = '0;
        forever begin
            @(negedge clk);
            if (ar_valid && ar_ready) begin
                ar_seen    = ar;
                ar_count   = ar_count + 1;
                beats_left = int'(ar.len) + 1;
                beat_addr  = ar.addr;
            end else if (r_valid && r_ready) begin
                beats_left = beats_left - 1;
                beat_addr  = beat_addr + 32'd4;
            end
            @(posedge clk);
            #2;
            ar_ready = rnd[2] | rnd[3];
            r_valid  = (beats_left > 0) && (rnd[4] | rnd[5]);
            r_data   = beat_addr;
            r_last   = (beats_left == 1);
        end
    end

    // all tasks below start and end 2 units after a rising edge
    task automatic push_line(input wb_entry_t entry);
        push       = 1'b1;
        push_entry = entry;
        @(posedge clk);
        #2;
        push = 1'b0;
    endtask

    task automatic read_line(input rd_req_t info, input l2_line_t exp, input ar_req_t exp_ar,
                             input logic from_mem);
        int ar_before;
        ar_before = ar_count;
        req       = 1'b1;
        req_info  = info;
        rdy       = 1'b0;
        @(negedge clk);
        while (!addr_ok) begin
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req = 1'b0;
        rdy = rnd[0] | rnd[1];
        @(negedge clk);
        while (!(data_ok && rdy)) begin
            @(posedge clk);
            #2;
            rdy = rnd[0] | rnd[1];
            @(negedge clk);
        end
        check_line("line_out", line_out, exp);
        @(posedge clk);
        #2;
        rdy = 1'b0;
        if (from_mem) begin
            if (ar_count != ar_before + 1) begin
                fail_run("a read from memory did not issue exactly one address beat");
            end
            check_ar("ar", ar_seen, exp_ar);
        end else if (ar_count != ar_before) begin
            fail_run("a write buffer hit issued an address beat");
        end
    endtask

    task automatic drain_line(input wb_entry_t exp);
        @(negedge clk);
        check_flag("drain_valid", drain_valid, 1'b1);
        check_entry("drain_entry", drain_entry, exp);
        @(posedge clk);
        #2;
        drain_done = 1'b1;
        @(posedge clk);
        #2;
        drain_done = 1'b0;
    endtask

    task automatic run_row(input logic [ROW_BITS-1:0] row);
        logic [7:0]  op;
        logic [31:0] addr;
        logic [7:0]  flags;
        rd_req_t     info;
        wb_entry_t   entry;
        wb_entry_t   exp_entry;
        l2_line_t    exp_line;
        ar_req_t     exp_ar;
        op                  = row[303:296];
        addr                = row[295:264];
        flags               = row[263:256];
        exp_line            = row[127:0];
        info.line_addr      = addr[31:4];
        info.dma            = flags[3];
        info.size           = flags[2:0];
        entry.line_addr     = addr[31:4];
        entry.line          = row[255:128];
        exp_entry.line_addr = addr[31:4];
        exp_entry.line      = exp_line;
        // a dma read is one beat of its own size, a line read four words
        exp_ar.addr = addr;
        if (flags[3]) begin
            exp_ar.len  = 8'd0;
            exp_ar.size = flags[2:0];
        end else begin
            exp_ar.len  = 8'd3;
            exp_ar.size = 3'd2;
        end
        case (op)
            8'h01: push_line(entry);
            8'h02: read_line(info, exp_line, exp_ar, 1'b0);
            8'h03: read_line(info, exp_line, exp_ar, 1'b1);
            8'h04: drain_line(exp_entry);
            8'h05: begin
                @(negedge clk);
                check_flag("full", full, flags[0]);
                check_flag("drain_valid", drain_valid, flags[1]);
                @(posedge clk);
                #2;
            end
            default: fail_run($sformatf("unknown opcode %h in the pattern file", op));
        endcase
    endtask

    initial begin
        rstn       = 1'b0;
        req        = 1'b0;
        req_info   = '0;
        rdy        = 1'b0;
        push       = 1'b0;
        push_entry = '0;
        drain_done = 1'b0;
        for (int i = 0; i < MAX_ROWS; i++) begin
            rows[i] = '0;
        end
        $readmemh("l2_mem_read_path_patterns.hex", rows);
        n_rows = 0;
        while (n_rows < MAX_ROWS && rows[n_rows][303:296] != 8'h00) begin
            n_rows = n_rows + 1;
        end
        if (n_rows == 0) begin
            fail_run("no rows were read from the pattern file");
        end
        limit = n_rows * 64;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        if (dut_i.asserts_i.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("handshake assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// File: l2_mem_read_path_patterns.hex
// op addr flags line[4 words, word 3 first] expected[4 words]; op 01 push 02 hit 03 mem 04 drain
// 05 status with flags bit0 full and bit1 drain_valid; flags bit3 dma and bits 2:0 size
01_00001000_00_aaaa0003_aaaa0002_aaaa0001_aaaa0000_00000000_00000000_00000000_00000000
02_00001000_00_00000000_00000000_00000000_00000000_aaaa0003_aaaa0002_aaaa0001_aaaa0000
03_00002000_00_00000000_00000000_00000000_00000000_0000200c_00002008_00002004_00002000
03_00001000_0a_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00001000
01_00001000_00_bbbb0003_bbbb0002_bbbb0001_bbbb0000_00000000_00000000_00000000_00000000
02_00001000_00_00000000_00000000_00000000_00000000_bbbb0003_bbbb0002_bbbb0001_bbbb0000
01_00003000_00_cccc0003_cccc0002_cccc0001_cccc0000_00000000_00000000_00000000_00000000
01_00004000_00_dddd0003_dddd0002_dddd0001_dddd0000_00000000_00000000_00000000_00000000
01_00005000_00_eeee0003_eeee0002_eeee0001_eeee0000_00000000_00000000_00000000_00000000
05_00000000_03_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000
04_00001000_00_00000000_00000000_00000000_00000000_bbbb0003_bbbb0002_bbbb0001_bbbb0000
04_00003000_00_00000000_00000000_00000000_00000000_cccc0003_cccc0002_cccc0001_cccc0000
04_00004000_00_00000000_00000000_00000000_00000000_dddd0003_dddd0002_dddd0001_dddd0000
04_00005000_00_00000000_00000000_00000000_00000000_eeee0003_eeee0002_eeee0001_eeee0000
05_00000000_00_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000
03_00003000_00_00000000_00000000_00000000_00000000_0000300c_00003008_00003004_00003000
03_00006000_08_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00006000

// File: l2_mem_read_path.f
+incdir+.
l2_mem_pkg.sv
write_buffer.sv
read_arbiter.sv
return_buffer.sv
l2_mem_read_path.sv
l2_mem_read_path_asserts.sv
l2_mem_read_path_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := l2_mem_read_path_tb
FILELIST   := l2_mem_read_path.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
